//--- Bender.yml
package:
  name: programmable_sequencer

sources:
  - hw/seq_pkg.sv
  - hw/seq_apb_regs.sv
  - hw/seq_fsm.sv
  - hw/seq_delay_timer.sv
  - hw/seq_channel_io.sv
  - hw/programmable_sequencer.sv
  - target: test
    files:
      - tb/programmable_sequencer_sva.sv
      - tb/tb_programmable_sequencer.sv

//--- hw/programmable_sequencer.sv
`timescale 1ns/1ps

module programmable_sequencer import seq_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [n_channels-1:0] step_done,
    output logic [n_channels-1:0] step_start,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // Register file outputs
    logic [step_w-1:0]  n_steps;
    logic               burst;
    logic [delay_w-1:0] delay_value;
    logic [chan_w-1:0]  step_channel;

    // Sequencer status back to the register file
    logic              busy;
    logic [step_w-1:0] current_step;

    // Handshakes between FSM, timer and channel IO
    logic start_req;
    logic timer_load;
    logic expired;
    logic chan_done;

    seq_apb_regs i_seq_apb_regs (
        .clock        (clock),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .busy         (busy),
        .current_step (current_step),
        .n_steps      (n_steps),
        .burst        (burst),
        .delay_value  (delay_value),
        .step_channel (step_channel)
    );

    seq_fsm i_seq_fsm (
        .clock        (clock),
        .arst_n       (arst_n),
        .enable       (enable),
        .n_steps      (n_steps),
        .burst        (burst),
        .chan_done    (chan_done),
        .expired      (expired),
        .start_req    (start_req),
        .timer_load   (timer_load),
        .busy         (busy),
        .current_step (current_step)
    );

    seq_delay_timer i_seq_delay_timer (
        .clock       (clock),
        .arst_n      (arst_n),
        .timer_load  (timer_load),
        .delay_value (delay_value),
        .expired     (expired)
    );

    seq_channel_io i_seq_channel_io (
        .clock        (clock),
        .arst_n       (arst_n),
        .start_req    (start_req),
        .step_channel (step_channel),
        .step_done    (step_done),
        .step_start   (step_start),
        .chan_done    (chan_done)
    );

endmodule

//--- hw/seq_apb_regs.sv
`timescale 1ns/1ps

module seq_apb_regs import seq_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  logic [step_w-1:0]     current_step,
    output logic [step_w-1:0]     n_steps,
    output logic                  burst,
    output logic [delay_w-1:0]    delay_value,
    output logic [chan_w-1:0]     step_channel
);

    // One channel number per step slot
    logic [chan_w-1:0] step_reg [n_slots];

    // Access phase of an APB transfer
    logic access;

    // Address decode
    logic               control_hit;
    logic               delay_hit;
    logic               status_hit;
    logic [n_slots-1:0] step_hit;
    logic               mapped;

    // Write strobe for the writable registers
    logic wr_en;

    assign access      = psel && penable;
    assign control_hit = paddr == reg_control_addr;
    assign delay_hit   = paddr == reg_delay_addr;
    assign status_hit  = paddr == reg_status_addr;

    // Each step register sits at its own word; addresses in between are unmapped
    always_comb begin
        for (int i = 0; i < n_slots; i++) begin
            step_hit[i] = paddr == reg_step_base_addr + apb_addr_w'(i * reg_step_stride);
        end
    end

    assign mapped = control_hit || delay_hit || status_hit || (|step_hit);

    // Status can only be read, so a write there is refused along with unmapped addresses
    assign wr_en   = access && pwrite && mapped && !status_hit;
    assign pslverr = access && (!mapped || (pwrite && status_hit));

    // No wait states, every transfer completes in its access phase
    assign pready = 1'b1;

    // Writes land on the access-phase edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            n_steps     <= '0;
            burst       <= 1'b0;
            delay_value <= '0;
            for (int i = 0; i < n_slots; i++) begin
                step_reg[i] <= '0;
            end
        end else if (wr_en) begin
            if (control_hit) begin
                n_steps <= pwdata[step_w-1:0];
                burst   <= pwdata[ctrl_burst_bit];
            end
            if (delay_hit) begin
                delay_value <= pwdata[delay_w-1:0];
            end
            for (int i = 0; i < n_slots; i++) begin
                if (step_hit[i]) begin
                    step_reg[i] <= pwdata[chan_w-1:0];
                end
            end
        end
    end

    // Read data follows the address directly and is zero outside the access phase
    always_comb begin
        prdata = '0;
        if (access) begin
            if (control_hit) begin
                prdata[step_w-1:0]     = n_steps;
                prdata[ctrl_burst_bit] = burst;
            end
            if (delay_hit) begin
                prdata[delay_w-1:0] = delay_value;
            end
            if (status_hit) begin
                prdata[status_busy_bit]                        = busy;
                prdata[status_step_lsb +: step_w]              = current_step;
            end
            for (int i = 0; i < n_slots; i++) begin
                if (step_hit[i]) begin
                    prdata[chan_w-1:0] = step_reg[i];
                end
            end
        end
    end

    // Channel of the slot the sequencer is on
    // A step index past the last slot reads as all ones, which names no channel,
    // so such steps are skipped just like a slot holding a bad channel number
    always_comb begin
        step_channel = '1;
        for (int i = 0; i < n_slots; i++) begin
            if (current_step == step_w'(i)) begin
                step_channel = step_reg[i];
            end
        end
    end

endmodule

//--- hw/seq_channel_io.sv
`timescale 1ns/1ps

module seq_channel_io import seq_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start_req,
    input  logic [chan_w-1:0]     step_channel,
    input  logic [n_channels-1:0] step_done,
    output logic [n_channels-1:0] step_start,
    output logic                  chan_done
);

    // One-hot form of the slot's channel number
    logic [n_channels-1:0] chan_onehot;

    // Low when the channel number is past the last real channel
    logic chan_valid;

    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            chan_onehot[i] = step_channel == chan_w'(i);
        end
    end

    assign chan_valid = |chan_onehot;

    // A channel that does not exist reports done at once, so its slot passes without a pulse
    assign chan_done = chan_valid ? |(chan_onehot & step_done) : 1'b1;

    // The pulse is registered, which puts it one cycle after s_start
    // start_req is a single cycle wide, so the pulse is too
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step_start <= '0;
        end else if (start_req) begin
            step_start <= chan_onehot;
        end else begin
            step_start <= '0;
        end
    end

endmodule

//--- hw/seq_delay_timer.sv
`timescale 1ns/1ps

module seq_delay_timer import seq_pkg::*; (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               timer_load,
    input  logic [delay_w-1:0] delay_value,
    output logic               expired
);

    // Remaining cycles of the inter-step delay
    logic [delay_w-1:0] count;

    // After a load with value d the counter reads d in the next cycle
    // and reaches zero d cycles later, so the FSM sits in s_delay for d+1 cycles
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (timer_load) begin
            count <= delay_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // The counter parks at zero, which keeps the flag up until the next load
    // A load of zero therefore expires in the very first delay cycle
    assign expired = count == '0;

endmodule

//--- hw/seq_fsm.sv
`timescale 1ns/1ps

module seq_fsm import seq_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              enable,
    input  logic [step_w-1:0] n_steps,
    input  logic              burst,
    input  logic              chan_done,
    input  logic              expired,
    output logic              start_req,
    output logic              timer_load,
    output logic              busy,
    output logic [step_w-1:0] current_step
);

    seq_state_t state;
    seq_state_t state_next;

    logic [step_w-1:0] step_next;

    // One bit wider than the step index so the last-step compare cannot wrap
    logic [step_w:0] step_plus_one;
    logic            last_step;

    // Set once a burst has run to its end, cleared when enable drops
    logic burst_done;

    assign step_plus_one = {1'b0, current_step} + 1'b1;

    // Also true when the step count was lowered below the current index mid-run
    assign last_step = step_plus_one >= {1'b0, n_steps};

    always_comb begin
        state_next = state;
        step_next  = current_step;
        case (state)
            s_idle: begin
                // A zero step count never starts, and a finished burst waits for enable to cycle
                if (enable && (n_steps != '0) && !burst_done) begin
                    state_next = s_start;
                    step_next  = '0;
                end
            end
            s_start: begin
                state_next = s_wait_done;
            end
            s_wait_done: begin
                // No timeout here, the channel may take as long as it needs
                if (chan_done) begin
                    state_next = s_delay;
                end
            end
            s_delay: begin
                if (expired) begin
                    if (last_step) begin
                        step_next  = '0;
                        // Looping only goes on while enable is still high at the sequence end
                        state_next = (burst || !enable) ? s_idle : s_start;
                    end else begin
                        step_next  = current_step + 1'b1;
                        state_next = s_start;
                    end
                end
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= s_idle;
            current_step <= '0;
        end else begin
            state        <= state_next;
            current_step <= step_next;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            burst_done <= 1'b0;
        end else if (!enable) begin
            burst_done <= 1'b0;
        end else if ((state == s_delay) && expired && last_step && burst) begin
            burst_done <= 1'b1;
        end
    end

    // Start request for the channel IO, which turns it into the actual pulse a cycle later
    assign start_req = state == s_start;

    // Timer starts on the same edge that moves us into s_delay
    assign timer_load = (state == s_wait_done) && chan_done;

    assign busy = state != s_idle;

endmodule

//--- hw/seq_pkg.sv
package seq_pkg;

    // Number of start/done channel pairs brought out of the sequencer
    localparam int n_channels = 5;

    // Number of programmable step slots in the register file
    localparam int n_slots = 5;

    // A channel number must be able to name every channel and still leave
    // at least one code free, which the sequencer treats as "no channel"
    localparam int chan_w = 3;

    // Step count and step index share one width
    localparam int step_w = 8;

    // Inter-step delay in clock cycles
    localparam int delay_w = 16;

    // APB bus sizes
    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    // Control register holds the step count in the low byte and the burst flag above it
    localparam logic [apb_addr_w-1:0] reg_control_addr = 12'h000;

    // Delay register, cycles between the done of one step and the start of the next
    localparam logic [apb_addr_w-1:0] reg_delay_addr = 12'h008;

    // Status register is read only
    localparam logic [apb_addr_w-1:0] reg_status_addr = 12'h00C;

    // First step register; the rest follow one word apart
    localparam logic [apb_addr_w-1:0] reg_step_base_addr = 12'h010;
    localparam int reg_step_stride = 4;

    // Bit position of the burst flag inside the control register
    localparam int ctrl_burst_bit = 8;

    // Bit positions inside the status register
    localparam int status_busy_bit = 0;
    localparam int status_step_lsb = 8;

    // Sequencer states
    // s_start lasts one cycle and requests the start pulse,
    // s_wait_done holds until the selected channel reports done,
    // s_delay runs the inter-step timer down to zero
    typedef enum logic [1:0] {
        s_idle      = 2'd0,
        s_start     = 2'd1,
        s_wait_done = 2'd2,
        s_delay     = 2'd3
    } seq_state_t;

endpackage

//--- sources.f
hw/seq_pkg.sv
hw/seq_apb_regs.sv
hw/seq_fsm.sv
hw/seq_delay_timer.sv
hw/seq_channel_io.sv
hw/programmable_sequencer.sv
tb/programmable_sequencer_sva.sv
tb/tb_programmable_sequencer.sv

//--- tb/programmable_sequencer_sva.sv
`timescale 1ns/1ps

module programmable_sequencer_sva import seq_pkg::*; (
    input logic                  clock,
    input logic                  arst_n,
    input logic [n_channels-1:0] step_start,
    input logic                  pready,
    input seq_state_t            state
);

    // Failed assertions so far, read by the testbench at the end of the run
    int failures = 0;

    // Only one channel is ever started at a time
    a_start_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(step_start))
        else begin
            $error("step_start has more than one bit set");
            failures++;
        end

    // The FSM leaves s_start after one cycle, so the pulse is one cycle wide
    a_start_single: assert property (@(posedge clock) disable iff (!arst_n)
        (step_start != '0) |=> (step_start == '0))
        else begin
            $error("step_start held for more than one cycle");
            failures++;
        end

    // The slave has no wait states
    a_pready_high: assert property (@(posedge clock) disable iff (!arst_n)
        pready)
        else begin
            $error("pready went low");
            failures++;
        end

    // A pulse always follows s_start, so the FSM is never idle during one
    a_no_start_idle: assert property (@(posedge clock) disable iff (!arst_n)
        (step_start != '0) |-> (state != s_idle))
        else begin
            $error("start pulse while the FSM is idle");
            failures++;
        end

endmodule

bind programmable_sequencer programmable_sequencer_sva i_programmable_sequencer_sva (
    .clock      (clock),
    .arst_n     (arst_n),
    .step_start (step_start),
    .pready     (pready),
    .state      (i_seq_fsm.state)
);

//--- tb/tb_programmable_sequencer.sv
`timescale 1ns/1ps

module tb_programmable_sequencer import seq_pkg::*; ();

    logic                  clock;
    logic                  arst_n;
    logic                  enable;
    logic [n_channels-1:0] step_done;
    logic [n_channels-1:0] step_start;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // Register image of the model
    logic [8:0]  model_control = '0;
    logic [15:0] model_delay   = '0;
    logic [2:0]  model_step [n_slots] = '{default: '0};

    // Predicted channel of each start pulse and its cycles after the last done
    // A spacing of 0 leaves the timing of that pulse unchecked
    int exp_chan[$];
    int exp_gap[$];

    int edge_count     = 0;
    int last_done_edge = 0;
    int pulse_count    = 0;
    int errors         = 0;
    int tests_run      = 0;
    int tests_failed   = 0;

    programmable_sequencer i_programmable_sequencer (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // Rising edges so far, read at each falling edge to time the pulses
    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Checks each start pulse against the predicted channel and spacing
    always @(negedge clock) begin
        int chan;
        int gap;
        // Done and start pulses are both timed by the edge that drove them
        // so their difference equals the spacing between the edges that sample them
        if (step_done != '0) begin
            last_done_edge = edge_count;
        end
        if (step_start != '0) begin
            pulse_count++;
            assert (exp_chan.size() != 0) else
                report_failure($sformatf("start pulse %b came when none was due", step_start));
            if (exp_chan.size() != 0) begin
                chan = exp_chan.pop_front();
                gap  = exp_gap.pop_front();
                assert (step_start == n_channels'(1 << chan)) else
                    report_mismatch($sformatf("start %b, expected channel %0d", step_start, chan));
                assert (gap == 0 || edge_count - last_done_edge == gap) else
                    report_mismatch($sformatf("pulse came %0d cycles after done, expected %0d",
                        edge_count - last_done_edge, gap));
            end
        end
    end

    // Answers each start pulse with a one-cycle done after a random latency
    initial begin
        logic [n_channels-1:0] pending;
        int                    latency;
        forever begin
            @(negedge clock);
            if (step_start != '0) begin
                pending = step_start;
                latency = $urandom_range(15, 0);
                repeat (latency) @(posedge clock);
                @(posedge clock);
                step_done <= pending;
                @(posedge clock);
                step_done <= '0;
            end
        end
    end

    task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
                                input logic [apb_data_w-1:0] wdata,
                                output logic [apb_data_w-1:0] rdata, output logic err);
        int waited;
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (!pready && waited < 16) begin
            @(negedge clock);
            waited++;
        end
        assert (pready) else report_failure("APB access never completed, pready stayed low");
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic bit is_mapped(input logic [apb_addr_w-1:0] addr);
        if (addr == 12'h000 || addr == 12'h008 || addr == 12'h00C) begin
            return 1'b1;
        end
        return addr >= 12'h010 && addr < 12'h010 + 4 * n_slots && addr[1:0] == 2'b00;
    endfunction

    task automatic write_reg(input logic [apb_addr_w-1:0] addr, input logic [apb_data_w-1:0] data);
        logic [apb_data_w-1:0] rdata;
        logic                  err;
        apb_transfer(1'b1, addr, data, rdata, err);
        assert (!err) else report_mismatch($sformatf("write to %h gave pslverr", addr));
        case (addr)
            12'h000: model_control = data[8:0];
            12'h008: model_delay   = data[15:0];
            default: model_step[(addr - 12'h010) >> 2] = data[2:0];
        endcase
    endtask

    task automatic check_read(input logic [apb_addr_w-1:0] addr);
        logic [apb_data_w-1:0] rdata;
        logic [apb_data_w-1:0] expected;
        logic                  err;
        expected = '0;
        // Status is only read while idle, so busy and step are both zero
        case (addr)
            12'h000: expected[8:0]  = model_control;
            12'h008: expected[15:0] = model_delay;
            12'h00C: expected       = '0;
            default: begin
                if (is_mapped(addr)) begin
                    expected[2:0] = model_step[(addr - 12'h010) >> 2];
                end
            end
        endcase
        apb_transfer(1'b0, addr, '0, rdata, err);
        assert (rdata == expected && err == !is_mapped(addr)) else
            report_mismatch($sformatf("read %h gave %h/%b, expected %h/%b",
                addr, rdata, err, expected, !is_mapped(addr)));
    endtask

    // A skipped slot still costs one full start, done and delay round of delay+3 cycles
    function automatic int build_expected(input int passes);
        int skipped;
        int pulses;
        int chan;
        skipped = 0;
        pulses  = 0;
        for (int p = 0; p < passes; p++) begin
            for (int s = 0; s < model_control[7:0]; s++) begin
                chan = (s < n_slots) ? model_step[s] : 7;
                if (chan < n_channels) begin
                    exp_chan.push_back(chan);
                    exp_gap.push_back(pulses == 0 ? 0 : (model_delay + 3) * (skipped + 1));
                    skipped = 0;
                    pulses++;
                end else begin
                    skipped++;
                end
            end
        end
        return pulses;
    endfunction

    // Slot 0 always holds a real channel so that every run pulses at least once
    task automatic program_sequence(input bit burst_mode);
        write_reg(12'h008, $urandom_range(20, 0));
        for (int s = 0; s < n_slots; s++) begin
            write_reg(12'(16 + 4 * s), (s == 0) ? $urandom_range(4, 0) : $urandom_range(7, 0));
        end
        write_reg(12'h000, {burst_mode, 8'($urandom_range(7, 1))});
    endtask

    task automatic wait_for_pulses(input int limit);
        int waited;
        waited = 0;
        while (exp_chan.size() != 0 && waited < limit) begin
            @(posedge clock);
            waited++;
        end
        assert (exp_chan.size() == 0) else
            report_failure($sformatf("timed out with %0d start pulses missing", exp_chan.size()));
        exp_chan.delete();
        exp_gap.delete();
    endtask

    task automatic wait_for_idle(input int limit);
        logic [apb_data_w-1:0] rdata;
        logic                  err;
        int                    waited;
        waited = 0;
        rdata  = '1;
        while (rdata[0] && waited < limit) begin
            apb_transfer(1'b0, 12'h00C, '0, rdata, err);
            waited++;
        end
        assert (!rdata[0]) else report_failure("sequencer still busy after the timeout");
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%-14s ok", name);
        end else begin
            tests_failed++;
            $display("%-14s FAILED, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int                    errors_before;
        int                    expected_pulses;
        int                    pulses_before;
        logic [apb_addr_w-1:0] addr;
        logic [apb_data_w-1:0] rdata;
        logic                  err;
        void'($urandom(32'hbf75_5afb));
        arst_n    = 1'b0;
        enable    = 1'b0;
        step_done = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        // Nothing may start after reset, nor with a step count of zero
        errors_before = errors;
        check_read(12'h00C);
        enable <= 1'b1;
        repeat (30) @(posedge clock);
        check_read(12'h00C);
        assert (pulse_count == 0) else report_mismatch("start pulse with zero steps");
        enable <= 1'b0;
        end_test("reset_zero", errors_before);

        errors_before = errors;
        for (int i = 0; i < 40; i++) begin
            case ($urandom_range(2, 0))
                0: addr = 12'h000;
                1: addr = 12'h008;
                default: addr = 12'(16 + 4 * $urandom_range(n_slots - 1, 0));
            endcase
            write_reg(addr, $urandom());
            check_read(addr);
        end
        // Addresses around the map hit both mapped and unmapped words
        for (int i = 0; i < 40; i++) begin
            addr = 12'($urandom_range(12'h03F, 0));
            if (!is_mapped(addr)) begin
                apb_transfer(1'b1, addr, $urandom(), rdata, err);
                assert (err) else report_mismatch($sformatf("write to %h not refused", addr));
            end
            check_read(addr);
        end
        apb_transfer(1'b1, 12'h00C, $urandom(), rdata, err);
        assert (err) else report_mismatch("write to status not refused");
        check_read(12'h00C);
        end_test("readback", errors_before);

        // In looping mode enable drops after the last pulse of the second pass
        for (int r = 0; r < 3; r++) begin
            errors_before = errors;
            program_sequence(1'b0);
            pulses_before   = pulse_count;
            expected_pulses = build_expected(2);
            enable <= 1'b1;
            wait_for_pulses(4000);
            enable <= 1'b0;
            wait_for_idle(200);
            assert (pulse_count - pulses_before == expected_pulses) else
                report_mismatch($sformatf("%0d pulses, expected %0d",
                    pulse_count - pulses_before, expected_pulses));
            end_test($sformatf("loop_order %0d", r), errors_before);
        end

        // Burst mode runs once, then stays quiet while enable is held
        for (int r = 0; r < 3; r++) begin
            errors_before = errors;
            program_sequence(1'b1);
            pulses_before   = pulse_count;
            expected_pulses = build_expected(1);
            enable <= 1'b1;
            wait_for_pulses(2000);
            wait_for_idle(200);
            repeat (60) @(posedge clock);
            check_read(12'h00C);
            assert (pulse_count - pulses_before == expected_pulses) else
                report_mismatch($sformatf("%0d burst pulses, expected %0d",
                    pulse_count - pulses_before, expected_pulses));
            enable <= 1'b0;
            end_test($sformatf("burst %0d", r), errors_before);
        end

        $display("tests run %0d, tests failed %0d, pulses %0d, errors %0d, sva failures %0d",
            tests_run, tests_failed, pulse_count, errors,
            i_programmable_sequencer.i_programmable_sequencer_sva.failures);
        if (errors == 0 && i_programmable_sequencer.i_programmable_sequencer_sva.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
